// File: src/bus_pkg.sv
`default_nettype none

package bus_pkg;

  localparam int unsigned bus_addr_w = 32;
  localparam int unsigned bus_data_w = 32;
  localparam int unsigned bus_be_w   = 4;
  localparam int unsigned reg_addr_w = 8;

  // Single-cycle request strobe from the host.
  typedef struct packed {
    logic                  strobe;
    logic                  we;
    logic [bus_addr_w-1:0] addr;
    logic [bus_be_w-1:0]   be;
    logic [bus_data_w-1:0] wdata;
  } bus_req_t;

  // Response, valid one cycle after the strobe.
  typedef struct packed {
    logic                  valid;
    logic [bus_data_w-1:0] rdata;
    logic                  err;
  } bus_rsp_t;

  // Device slots; dev_none marks an unmapped address.
  typedef enum logic [2:0] {
    dev_ram   = 3'd0,
    dev_gpio  = 3'd1,
    dev_pwm   = 3'd2,
    dev_timer = 3'd3,
    dev_none  = 3'd4
  } dev_sel_e;

  localparam int unsigned dev_num = 4;

  ////////////////////////////////////////
  // Address map.
  ////////////////////////////////////////

  localparam logic [bus_addr_w-1:0] ram_base     = 32'h0010_0000;
  localparam logic [bus_addr_w-1:0] ram_size     = 32'h0001_0000;
  localparam logic [bus_addr_w-1:0] gpio_base    = 32'h8000_0000;
  localparam logic [bus_addr_w-1:0] pwm_base     = 32'h8000_1000;
  localparam logic [bus_addr_w-1:0] timer_base   = 32'h8000_2000;
  localparam logic [bus_addr_w-1:0] reg_win_size = 32'h0000_1000;

  // Byte-lane merge of write data into an existing word.
  function automatic logic [bus_data_w-1:0] apply_be(
    input logic [bus_data_w-1:0] old_data,
    input logic [bus_data_w-1:0] new_data,
    input logic [bus_be_w-1:0]   be
  );
    logic [bus_data_w-1:0] merged;
    merged = old_data;
    for (int i = 0; i < bus_be_w; i++) begin
      if (be[i]) begin
        merged[8*i +: 8] = new_data[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

// File: src/periph_pkg.sv
`default_nettype none

package periph_pkg;

  ////////////////////////////////////////
  // GPIO registers.
  ////////////////////////////////////////

  localparam int unsigned gpio_out_off = 'h00;
  localparam int unsigned gpio_in_off  = 'h04;

  ////////////////////////////////////////
  // PWM registers.
  ////////////////////////////////////////

  // Channel n sits at n * stride.
  localparam int unsigned pwm_duty_stride = 4;

  ////////////////////////////////////////
  // Timer registers.
  ////////////////////////////////////////

  localparam int unsigned timer_mtime_off    = 'h00;
  localparam int unsigned timer_mtimecmp_off = 'h04;

  // Compare parked at the top so no interrupt fires out of reset.
  localparam logic [31:0] timer_cmp_reset = 32'hffff_ffff;

endpackage

`default_nettype wire

// File: src/bus_decode.sv
`default_nettype none

module bus_decode (
  input  logic                                     clk_sys_i,
  input  logic                                     rst_i,
  input  bus_pkg::bus_req_t                        host_req_i,
  output bus_pkg::bus_rsp_t                        host_rsp_o,
  output bus_pkg::bus_req_t [bus_pkg::dev_num-1:0] dev_req_o,
  input  bus_pkg::bus_rsp_t [bus_pkg::dev_num-1:0] dev_rsp_i
);

  import bus_pkg::*;

  dev_sel_e              sel_d;
  dev_sel_e              sel_q;
  logic                  pend_q;
  logic [bus_addr_w-1:0] ram_off;
  logic [bus_addr_w-1:0] reg_off;

  // Windows are size aligned, so a mask compare is enough.
  function automatic logic in_window(
    input logic [bus_addr_w-1:0] addr,
    input logic [bus_addr_w-1:0] base,
    input logic [bus_addr_w-1:0] size
  );
    return (addr & ~(size - 1'b1)) == base;
  endfunction

  always_comb begin
    sel_d = dev_none;
    if (in_window(host_req_i.addr, ram_base, ram_size)) begin
      sel_d = dev_ram;
    end else if (in_window(host_req_i.addr, gpio_base, reg_win_size)) begin
      sel_d = dev_gpio;
    end else if (in_window(host_req_i.addr, pwm_base, reg_win_size)) begin
      sel_d = dev_pwm;
    end else if (in_window(host_req_i.addr, timer_base, reg_win_size)) begin
      sel_d = dev_timer;
    end
  end

  assign ram_off = host_req_i.addr & (ram_size - 1'b1);
  assign reg_off = bus_addr_w'(host_req_i.addr[reg_addr_w-1:0]);

  // Fan out, strobe only the selected slot.
  always_comb begin
    for (int i = 0; i < dev_num; i++) begin
      dev_req_o[i]        = host_req_i;
      dev_req_o[i].strobe = host_req_i.strobe && (sel_d == dev_sel_e'(i));
      dev_req_o[i].addr   = (dev_sel_e'(i) == dev_ram) ? ram_off : reg_off;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      pend_q <= 1'b0;
      sel_q  <= dev_none;
    end else begin
      pend_q <= host_req_i.strobe;
      if (host_req_i.strobe) begin
        sel_q <= sel_d;
      end
    end
  end

  // Return path, one cycle behind the request.
  always_comb begin
    host_rsp_o = '0;
    if (pend_q) begin
      if (sel_q == dev_none) begin
        host_rsp_o.valid = 1'b1;
        host_rsp_o.err   = 1'b1;
      end else begin
        host_rsp_o = dev_rsp_i[2'(sel_q)];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/sram_dev.sv
`default_nettype none

module sram_dev #(
  parameter int unsigned MemWords = 16384
) (
  input  logic              clk_sys_i,
  input  bus_pkg::bus_req_t req_i,
  output bus_pkg::bus_rsp_t rsp_o
);

  import bus_pkg::*;

  localparam int unsigned word_addr_w = $clog2(MemWords);

  logic [bus_data_w-1:0]  mem_q [MemWords];
  logic [word_addr_w-1:0] word_addr;
  logic [bus_data_w-1:0]  rdata_q;
  logic                   valid_q;

  // Byte address in, word index out.
  assign word_addr = req_i.addr[word_addr_w+1:2];

  always_ff @(posedge clk_sys_i) begin
    if (req_i.strobe && req_i.we) begin
      for (int i = 0; i < bus_be_w; i++) begin
        if (req_i.be[i]) begin
          mem_q[word_addr][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
    if (req_i.strobe) begin
      rdata_q <= mem_q[word_addr];
    end
    valid_q <= req_i.strobe;
  end

  assign rsp_o.valid = valid_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;

endmodule

`default_nettype wire

// File: src/gpio_dev.sv
`default_nettype none

module gpio_dev #(
  parameter int unsigned GpiWidth = 8,
  parameter int unsigned GpoWidth = 16
) (
  input  logic                clk_sys_i,
  input  logic                rst_i,
  input  bus_pkg::bus_req_t   req_i,
  output bus_pkg::bus_rsp_t   rsp_o,
  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o
);

  import bus_pkg::*;
  import periph_pkg::*;

  logic [GpoWidth-1:0]   gp_out_q;
  logic [GpiWidth-1:0]   gp_meta_q;
  logic [GpiWidth-1:0]   gp_in_q;
  logic [reg_addr_w-1:0] off;
  logic [bus_data_w-1:0] rdata_q;
  logic                  valid_q;

  assign off = req_i.addr[reg_addr_w-1:0];

  // Two-flop input synchroniser.
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      gp_meta_q <= '0;
      gp_in_q   <= '0;
    end else begin
      gp_meta_q <= gp_i;
      gp_in_q   <= gp_meta_q;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      gp_out_q <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= req_i.strobe;
      if (req_i.strobe && req_i.we && off == reg_addr_w'(gpio_out_off)) begin
        gp_out_q <= GpoWidth'(apply_be(bus_data_w'(gp_out_q), req_i.wdata, req_i.be));
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i.strobe) begin
      if (off == reg_addr_w'(gpio_out_off)) begin
        rdata_q <= bus_data_w'(gp_out_q);
      end else if (off == reg_addr_w'(gpio_in_off)) begin
        rdata_q <= bus_data_w'(gp_in_q);
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign gp_o        = gp_out_q;
  assign rsp_o.valid = valid_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;

endmodule

`default_nettype wire

// File: src/pwm_dev.sv
`default_nettype none

module pwm_dev #(
  parameter int unsigned PwmWidth   = 12,
  parameter int unsigned PwmCtrSize = 8
) (
  input  logic                clk_sys_i,
  input  logic                rst_i,
  input  bus_pkg::bus_req_t   req_i,
  output bus_pkg::bus_rsp_t   rsp_o,
  output logic [PwmWidth-1:0] pwm_o
);

  import bus_pkg::*;
  import periph_pkg::*;

  logic [PwmCtrSize-1:0]               ctr_q;
  logic [PwmWidth-1:0][PwmCtrSize-1:0] duty_q;
  logic [PwmWidth-1:0]                 pwm_q;
  logic [reg_addr_w-1:0]               off;
  int unsigned                         ch_idx;
  logic                                hit;
  logic [bus_data_w-1:0]               rdata_q;
  logic                                valid_q;

  // Offset to channel, only aligned offsets below the channel count hit.
  assign off    = req_i.addr[reg_addr_w-1:0];
  assign ch_idx = int'(off) / pwm_duty_stride;
  assign hit    = (ch_idx < PwmWidth) && (int'(off) % pwm_duty_stride == 0);

  ////////////////////////////////////////
  // Counter and outputs.
  ////////////////////////////////////////

  // Counter wraps every 2^PwmCtrSize cycles.
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      ctr_q <= '0;
      pwm_q <= '0;
    end else begin
      ctr_q <= ctr_q + 1'b1;
      for (int i = 0; i < PwmWidth; i++) begin
        pwm_q[i] <= ctr_q < duty_q[i];
      end
    end
  end

  ////////////////////////////////////////
  // Register access.
  ////////////////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      duty_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.strobe;
      if (req_i.strobe && req_i.we && hit) begin
        duty_q[ch_idx] <= req_i.wdata[PwmCtrSize-1:0];
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i.strobe) begin
      rdata_q <= hit ? bus_data_w'(duty_q[ch_idx]) : '0;
    end
  end

  assign pwm_o       = pwm_q;
  assign rsp_o.valid = valid_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;

endmodule

`default_nettype wire

// File: src/timer_dev.sv
`default_nettype none

module timer_dev (
  input  logic              clk_sys_i,
  input  logic              rst_i,
  input  bus_pkg::bus_req_t req_i,
  output bus_pkg::bus_rsp_t rsp_o,
  output logic              irq_o
);

  import bus_pkg::*;
  import periph_pkg::*;

  logic [bus_data_w-1:0] mtime_q;
  logic [bus_data_w-1:0] mtimecmp_q;
  logic                  irq_q;
  logic [reg_addr_w-1:0] off;
  logic                  wr;
  logic                  mtime_sel;
  logic                  cmp_sel;
  logic [bus_data_w-1:0] rdata_q;
  logic                  valid_q;

  assign off       = req_i.addr[reg_addr_w-1:0];
  assign wr        = req_i.strobe && req_i.we;
  assign mtime_sel = off == reg_addr_w'(timer_mtime_off);
  assign cmp_sel   = off == reg_addr_w'(timer_mtimecmp_off);

  ////////////////////////////////////////
  // Time base and compare.
  ////////////////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= timer_cmp_reset;
      irq_q      <= 1'b0;
    end else begin
      // A write to mtime wins over the increment.
      if (wr && mtime_sel) begin
        mtime_q <= apply_be(mtime_q, req_i.wdata, req_i.be);
      end else begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr && cmp_sel) begin
        mtimecmp_q <= apply_be(mtimecmp_q, req_i.wdata, req_i.be);
      end
      // Level irq, held while time is at or past compare.
      irq_q <= mtime_q >= mtimecmp_q;
    end
  end

  ////////////////////////////////////////
  // Register reads.
  ////////////////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.strobe;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i.strobe) begin
      if (mtime_sel) begin
        rdata_q <= mtime_q;
      end else if (cmp_sel) begin
        rdata_q <= mtimecmp_q;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign irq_o       = irq_q;
  assign rsp_o.valid = valid_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;

endmodule

`default_nettype wire

// File: src/periph_system.sv
`default_nettype none

module periph_system #(
  parameter int unsigned GpiWidth   = 8,
  parameter int unsigned GpoWidth   = 16,
  parameter int unsigned PwmWidth   = 12,
  parameter int unsigned PwmCtrSize = 8,
  parameter int unsigned MemWords   = 16384
) (
  input  logic                clk_sys_i,
  input  logic                rst_i,
  input  bus_pkg::bus_req_t   bus_req_i,
  input  logic [GpiWidth-1:0] gp_i,
  output bus_pkg::bus_rsp_t   bus_rsp_o,
  output logic [GpoWidth-1:0] gp_o,
  output logic [PwmWidth-1:0] pwm_o,
  output logic                timer_irq_o
);

  import bus_pkg::*;

  // One request and one response per device slot.
  bus_req_t [dev_num-1:0] dev_req;
  bus_rsp_t [dev_num-1:0] dev_rsp;

  bus_decode u_decode (
    .clk_sys_i (clk_sys_i),
    .rst_i     (rst_i),
    .host_req_i(bus_req_i),
    .host_rsp_o(bus_rsp_o),
    .dev_req_o (dev_req),
    .dev_rsp_i (dev_rsp)
  );

  sram_dev #(
    .MemWords(MemWords)
  ) u_ram (
    .clk_sys_i(clk_sys_i),
    .req_i    (dev_req[dev_ram]),
    .rsp_o    (dev_rsp[dev_ram])
  );

  gpio_dev #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) u_gpio (
    .clk_sys_i(clk_sys_i),
    .rst_i    (rst_i),
    .req_i    (dev_req[dev_gpio]),
    .rsp_o    (dev_rsp[dev_gpio]),
    .gp_i     (gp_i),
    .gp_o     (gp_o)
  );

  pwm_dev #(
    .PwmWidth  (PwmWidth),
    .PwmCtrSize(PwmCtrSize)
  ) u_pwm (
    .clk_sys_i(clk_sys_i),
    .rst_i    (rst_i),
    .req_i    (dev_req[dev_pwm]),
    .rsp_o    (dev_rsp[dev_pwm]),
    .pwm_o    (pwm_o)
  );

  timer_dev u_timer (
    .clk_sys_i(clk_sys_i),
    .rst_i    (rst_i),
    .req_i    (dev_req[dev_timer]),
    .rsp_o    (dev_rsp[dev_timer]),
    .irq_o    (timer_irq_o)
  );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`default_nettype none

module tb_clock #(
  parameter int unsigned Period      = 40,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_o
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    rst_o = 1'b1;
  end

  always #(Period / 2) clk_o = ~clk_o;

  // Release on a falling edge, clear of the sampling edge.
  initial begin
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: bench/tb_checker.sv
`default_nettype none

module tb_checker #(
  parameter int unsigned GpiWidth   = 8,
  parameter int unsigned GpoWidth   = 16,
  parameter int unsigned PwmWidth   = 12,
  parameter int unsigned PwmCtrSize = 8
) (
  input wire logic                clk_i,
  input wire logic                rst_i,
  input wire bus_pkg::bus_req_t   bus_req_i,
  input wire bus_pkg::bus_rsp_t   bus_rsp_i,
  input wire logic [GpiWidth-1:0] gp_i,
  input wire logic [GpoWidth-1:0] gp_o_i,
  input wire logic [PwmWidth-1:0] pwm_i,
  input wire logic                irq_i,
  input wire logic [3:0]          test_num_i,
  input wire logic                pwm_window_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import bus_pkg::*;
  import periph_pkg::*;

  // Reference model state.
  logic [31:0]           ram_m [int];
  logic [31:0]           ram_known [int];
  logic [GpoWidth-1:0]   gpo_m;
  logic [GpiWidth-1:0]   gpi_d1;
  logic [GpiWidth-1:0]   gpi_d2;
  logic [PwmCtrSize-1:0] duty_m [PwmWidth];
  logic [31:0]           mtime_m;
  logic [31:0]           cmp_m;
  logic                  irq_m;

  // Expected response of the request seen at the last edge.
  logic        pend;
  logic        exp_err;
  logic [31:0] exp_data;
  logic [31:0] exp_mask;

  int pwm_high [PwmWidth];
  logic window_q;
  int checks;
  int errors;
  int test_checks;
  int test_errors;
  int tests_run;
  int tests_failed;

  initial begin
    pend     = 1'b0;
    window_q = 1'b0;
    checks   = 0;
    errors   = 0;
    test_checks  = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < PwmWidth; i++) begin
      pwm_high[i] = 0;
    end
  end

  function automatic string test_name(input logic [3:0] n);
    case (n)
      4'd1:    return "ram";
      4'd2:    return "unmapped";
      4'd3:    return "gpio";
      4'd4:    return "pwm";
      4'd5:    return "timer";
      default: return "idle";
    endcase
  endfunction

  // Byte merge: lanes with an enable take the new byte.
  function automatic logic [31:0] merge_bytes(
    input logic [31:0] old_w,
    input logic [31:0] new_w,
    input logic [3:0]  be
  );
    logic [31:0] lane_mask;
    lane_mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~lane_mask) | (new_w & lane_mask);
  endfunction

  function automatic logic in_range(
    input logic [31:0] a,
    input logic [31:0] base,
    input logic [31:0] size
  );
    return (a >= base) && (a - base < size);
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    test_checks++;
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name(test_num_i), what, exp, act);
    end
  endtask

  task automatic note_error(input string msg);
    errors++;
    test_errors++;
    $display("Error in test %s: %s", test_name(test_num_i), msg);
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %0d %s: ok, %0d checks", test_num_i, test_name(test_num_i), test_checks);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors in %0d checks", test_num_i,
               test_name(test_num_i), test_errors, test_checks);
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic print_counts();
    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
  endtask

  ////////////////////////////////////////
  // Per-cycle compare and model update.
  ////////////////////////////////////////

  always @(posedge clk_i) begin : monitor
    logic [31:0] a;
    logic [31:0] off;
    logic [31:0] mt_next;
    logic        irq_next;
    int          w;
    if (rst_i) begin
      pend    = 1'b0;
      gpo_m   = '0;
      gpi_d1  = '0;
      gpi_d2  = '0;
      mtime_m = '0;
      cmp_m   = timer_cmp_reset;
      irq_m   = 1'b0;
      for (int i = 0; i < PwmWidth; i++) begin
        duty_m[i] = '0;
      end
    end else begin
      check_value("rsp valid", 32'(pend), 32'(bus_rsp_i.valid));
      if (pend) begin
        check_value("rsp err", 32'(exp_err), 32'(bus_rsp_i.err));
        if (exp_mask != 0) begin
          check_value("rsp data", exp_data & exp_mask, bus_rsp_i.rdata & exp_mask);
        end
      end
      check_value("gp_o", 32'(gpo_m), 32'(gp_o_i));
      check_value("timer_irq_o", 32'(irq_m), 32'(irq_i));

      // Interrupt follows the timer state before this edge.
      irq_next = mtime_m >= cmp_m;
      mt_next  = mtime_m + 1;
      pend     = bus_req_i.strobe;
      exp_err  = 1'b0;
      exp_data = '0;
      exp_mask = '0;
      a        = bus_req_i.addr;
      if (bus_req_i.strobe) begin
        if (in_range(a, ram_base, ram_size)) begin
          off = a - ram_base;
          w   = int'(off[15:2]);
          if (!ram_m.exists(w)) begin
            ram_m[w]     = '0;
            ram_known[w] = '0;
          end
          if (bus_req_i.we) begin
            ram_m[w]     = merge_bytes(ram_m[w], bus_req_i.wdata, bus_req_i.be);
            ram_known[w] = merge_bytes(ram_known[w], 32'hffff_ffff, bus_req_i.be);
          end else begin
            exp_data = ram_m[w];
            exp_mask = ram_known[w];
          end
        end else if (in_range(a, gpio_base, reg_win_size)) begin
          off      = a - gpio_base;
          exp_mask = '1;
          if (off == gpio_out_off) begin
            exp_data = 32'(gpo_m);
            if (bus_req_i.we) begin
              gpo_m = GpoWidth'(merge_bytes(32'(gpo_m), bus_req_i.wdata, bus_req_i.be));
            end
          end else if (off == gpio_in_off) begin
            exp_data = 32'(gpi_d2);
          end
        end else if (in_range(a, pwm_base, reg_win_size)) begin
          off      = a - pwm_base;
          exp_mask = '1;
          if (off % pwm_duty_stride == 0 && off / pwm_duty_stride < PwmWidth) begin
            w        = int'(off / pwm_duty_stride);
            exp_data = 32'(duty_m[w]);
            if (bus_req_i.we) begin
              duty_m[w] = bus_req_i.wdata[PwmCtrSize-1:0];
            end
          end
        end else if (in_range(a, timer_base, reg_win_size)) begin
          off      = a - timer_base;
          exp_mask = '1;
          if (off == timer_mtime_off) begin
            exp_data = mtime_m;
            if (bus_req_i.we) begin
              mt_next = merge_bytes(mtime_m, bus_req_i.wdata, bus_req_i.be);
            end
          end else if (off == timer_mtimecmp_off) begin
            exp_data = cmp_m;
            if (bus_req_i.we) begin
              cmp_m = merge_bytes(cmp_m, bus_req_i.wdata, bus_req_i.be);
            end
          end
        end else begin
          exp_err  = 1'b1;
          exp_mask = '1;
        end
      end
      mtime_m = mt_next;
      irq_m   = irq_next;
      gpi_d2  = gpi_d1;
      gpi_d1  = gp_i;

      // High-cycle count over the PWM window.
      if (pwm_window_i) begin
        for (int i = 0; i < PwmWidth; i++) begin
          pwm_high[i] += int'(pwm_i[i]);
        end
      end else if (window_q) begin
        for (int i = 0; i < PwmWidth; i++) begin
          check_value($sformatf("pwm_o[%0d] high cycles", i), 32'(duty_m[i]), 32'(pwm_high[i]));
          pwm_high[i] = 0;
        end
      end
      window_q = pwm_window_i;
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_top.sv
`default_nettype none

module tb_top;

  timeunit 1ns;
  timeprecision 1ps;

  import bus_pkg::*;
  import periph_pkg::*;

  localparam int unsigned GpiWidth   = 8;
  localparam int unsigned GpoWidth   = 16;
  localparam int unsigned PwmWidth   = 12;
  localparam int unsigned PwmCtrSize = 8;
  localparam int unsigned MemWords   = 16384;
  localparam int unsigned RamOps     = 200;
  localparam int unsigned UnmapOps   = 60;

  // Cycle budget of each test, then a margin on the sum.
  localparam int unsigned RunCycles = 16 + 2 * RamOps + 10 + 3 * UnmapOps + 10
                                    + 30 * 4 + 8 * 8 + 10 + 2 * PwmWidth + 260
                                    + 50 + 40 + 210 + 40;
  localparam int unsigned LimitNs   = 2 * RunCycles * 40;

  logic                clk;
  logic                rst;
  bus_req_t            req;
  bus_rsp_t            rsp;
  logic [GpiWidth-1:0] gp_in;
  logic [GpoWidth-1:0] gp_out;
  logic [PwmWidth-1:0] pwm;
  logic                irq;
  logic [3:0]          test_num;
  logic                pwm_window;
  logic [31:0]         lfsr_q;
  logic [31:0]         addr_list [RamOps];

  tb_clock u_clock (
    .clk_o(clk),
    .rst_o(rst)
  );

  periph_system #(
    .GpiWidth  (GpiWidth),
    .GpoWidth  (GpoWidth),
    .PwmWidth  (PwmWidth),
    .PwmCtrSize(PwmCtrSize),
    .MemWords  (MemWords)
  ) periph_system_i (
    .clk_sys_i  (clk),
    .rst_i      (rst),
    .bus_req_i  (req),
    .gp_i       (gp_in),
    .bus_rsp_o  (rsp),
    .gp_o       (gp_out),
    .pwm_o      (pwm),
    .timer_irq_o(irq)
  );

  tb_checker #(
    .GpiWidth  (GpiWidth),
    .GpoWidth  (GpoWidth),
    .PwmWidth  (PwmWidth),
    .PwmCtrSize(PwmCtrSize)
  ) u_chk (
    .clk_i       (clk),
    .rst_i       (rst),
    .bus_req_i   (req),
    .bus_rsp_i   (rsp),
    .gp_i        (gp_in),
    .gp_o_i      (gp_out),
    .pwm_i       (pwm),
    .irq_i       (irq),
    .test_num_i  (test_num),
    .pwm_window_i(pwm_window)
  );

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic is_mapped(input logic [31:0] a);
    return (a >= ram_base && a - ram_base < ram_size)
        || (a >= gpio_base && a - gpio_base < 3 * reg_win_size);
  endfunction

  task automatic issue(input logic we, input logic [31:0] addr, input logic [3:0] be,
                       input logic [31:0] data);
    @(negedge clk);
    req.strobe = 1'b1;
    req.we     = we;
    req.addr   = addr;
    req.be     = be;
    req.wdata  = data;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      req.strobe = 1'b0;
    end
  endtask

  // Response is valid during the cycle after the strobe.
  task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
    issue(1'b0, addr, 4'hf, '0);
    idle(1);
    data = rsp.rdata;
  endtask

  initial begin : watchdog
    #(LimitNs * 1ns);
    $display("Watchdog: run did not finish within %0d ns", LimitNs);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : sequence_run
    logic [31:0] a;
    logic [31:0] m;
    int          d;
    int          waited;
    req        = '0;
    gp_in      = '0;
    test_num   = 4'd0;
    pwm_window = 1'b0;
    lfsr_q     = 32'hd2da8517;
    @(negedge clk);
    while (rst) @(negedge clk);

    test_num = 4'd1;
    for (int i = 0; i < RamOps; i++) begin
      addr_list[i] = ram_base + (rand_bits(14) << 2);
      issue(1'b1, addr_list[i], 4'(rand_bits(4)), rand_bits(32));
    end
    for (int i = 0; i < RamOps; i++) begin
      issue(1'b0, addr_list[i], 4'hf, '0);
    end
    idle(3);
    u_chk.end_test();

    // Unmapped accesses mixed with mapped reads.
    test_num = 4'd2;
    for (int i = 0; i < UnmapOps; i++) begin
      a = rand_bits(32);
      while (is_mapped(a)) a = rand_bits(32);
      issue(rand_bits(1) == 1, a, 4'(rand_bits(4)), rand_bits(32));
      issue(1'b0, addr_list[rand_bits(7)], 4'hf, '0);
      issue(1'b0, gpio_base + gpio_out_off, 4'hf, '0);
    end
    idle(3);
    u_chk.end_test();

    test_num = 4'd3;
    for (int i = 0; i < 30; i++) begin
      issue(1'b1, gpio_base + gpio_out_off, 4'(rand_bits(4)), rand_bits(32));
      issue(1'b0, gpio_base + gpio_out_off, 4'hf, '0);
      idle(2);
    end
    for (int i = 0; i < 8; i++) begin
      gp_in = GpiWidth'(rand_bits(GpiWidth));
      idle(4);
      issue(1'b0, gpio_base + gpio_in_off, 4'hf, '0);
      idle(3);
    end
    u_chk.end_test();

    test_num = 4'd4;
    for (int ch = 0; ch < PwmWidth; ch++) begin
      issue(1'b1, pwm_base + ch * pwm_duty_stride, 4'hf, rand_bits(32));
    end
    for (int ch = 0; ch < PwmWidth; ch++) begin
      issue(1'b0, pwm_base + ch * pwm_duty_stride, 4'hf, '0);
    end
    idle(3);
    @(negedge clk);
    pwm_window = 1'b1;
    repeat (1 << PwmCtrSize) @(negedge clk);
    pwm_window = 1'b0;
    idle(2);
    u_chk.end_test();

    test_num = 4'd5;
    read_word(timer_base + timer_mtime_off, m);
    idle(5 + int'(rand_bits(5)));
    read_word(timer_base + timer_mtime_off, m);
    d = 20 + int'(rand_bits(8) % 181);
    issue(1'b1, timer_base + timer_mtimecmp_off, 4'hf, m + d);
    waited = 0;
    idle(1);
    while (!irq && waited < d + 3) begin
      waited++;
      @(negedge clk);
    end
    if (!irq) begin
      u_chk.note_error($sformatf("timer_irq_o not raised within %0d cycles", d + 3));
    end else if (waited < 10) begin
      u_chk.note_error($sformatf("timer_irq_o raised early, after %0d cycles", waited));
    end
    idle(20);
    issue(1'b1, timer_base + timer_mtimecmp_off, 4'hf, timer_cmp_reset);
    idle(5);
    if (irq) begin
      u_chk.note_error("timer_irq_o still high after compare reset");
    end
    u_chk.end_test();

    u_chk.print_counts();
    if (u_chk.errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
src/bus_pkg.sv
src/periph_pkg.sv
src/bus_decode.sv
src/sram_dev.sv
src/gpio_dev.sv
src/pwm_dev.sv
src/timer_dev.sv
src/periph_system.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_top
FILELIST  ?= src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
